// ==== vita_tx_chain.f ====
hdl/vita_tx_pkg.sv
hdl/vita_tx_setting_regs.sv
hdl/vita_tx_control.sv
hdl/trigger_context_pkt.sv
hdl/gen_context_pkt.sv
hdl/context_pkt_mux.sv
hdl/vita_tx_chain.sv
verification/vita_tx_chain_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
   --top-module vita_tx_chain_tb \
   -f vita_tx_chain.f \
   -o vita_tx_chain_sim

./obj_dir/vita_tx_chain_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^TB PASSED$" "$LOG"; then
   exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1

// ==== verification/vita_tx_chain_tb.sv ====
// ##########################################################
// Directed testbench for the timed transmit back end
// Entries come from a queue, reports are gathered word by word
// The stream id written in the first test is used for all packets
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module vita_tx_chain_tb import vita_tx_pkg::*; ();

   localparam int          CLK_PERIOD   = 20;
   localparam int          RESET_CYCLES = 8;
   localparam int          NUM_TESTS    = 6;
   localparam int          TEST_CYCLES  = 600;
   localparam int          WAIT_LIMIT   = 200;
   localparam int          WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD;
   localparam logic [31:0] SEED         = 32'hc8b4_6a20;

   logic          clk;
   logic          arst_n;
   logic          set_stb;
   setting_bus_t  set_bus;
   logic [63:0]   vita_time;
   sample_entry_t fifo_data;
   logic          fifo_src_rdy;
   logic          fifo_dst_rdy;
   logic          strobe;
   logic [31:0]   sample;
   logic          run;
   logic          underrun;
   stream_word_t  err_data;
   logic          err_src_rdy;
   logic          err_dst_rdy;

   // Entries still to be offered, the feeder owns the read index
   sample_entry_t entry_q [$];
   sample_entry_t stage_q [$];
   int            entry_rd;
   logic          popped;

   // Report words as they left the DUT, the test side owns the read index
   stream_word_t  rx_q [$];
   int            rx_rd;
   logic          stalled;
   stream_word_t  held_word;
   int            stall_errors;

   logic [1:0]    bp_mode;
   string         current_test;
   int            error_count;
   int            check_count;
   int            test_count;
   int            errors_at_start;
   logic [31:0]   stream_id;
   logic [3:0]    err_pkts;
   logic [3:0]    flow_pkts;

   vita_tx_chain DUT (
      .clk_i(clk), .arst_n_i(arst_n),
      .set_stb_i(set_stb), .set_i(set_bus),
      .vita_time_i(vita_time),
      .sample_fifo_i(fifo_data),
      .sample_fifo_src_rdy_i(fifo_src_rdy),
      .sample_fifo_dst_rdy_o(fifo_dst_rdy),
      .strobe_i(strobe), .sample_o(sample),
      .run_o(run), .underrun_o(underrun),
      .err_data_o(err_data), .err_src_rdy_o(err_src_rdy), .err_dst_rdy_i(err_dst_rdy)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired in test %s, the DUT stopped responding", current_test);
      $display("TB FAILED");
      $finish;
   end

   // Feeder presents the head entry and steps past it after a transfer
   initial begin
      fifo_src_rdy = 1'b0;
      fifo_data    = '0;
      entry_rd     = 0;
      forever begin
         @(negedge clk);
         if (popped) begin
            entry_rd = entry_rd + 1;
         end
         if (entry_rd < entry_q.size()) begin
            fifo_src_rdy = 1'b1;
            fifo_data    = entry_q[entry_rd];
         end else begin
            fifo_src_rdy = 1'b0;
         end
      end
   end

   initial begin
      err_dst_rdy = 1'b1;
      forever begin
         @(negedge clk);
         if (bp_mode == 2'd1) begin
            err_dst_rdy = 1'b0;
         end else if (bp_mode == 2'd2) begin
            err_dst_rdy = (($urandom() % 32'd3) != 32'd0);
         end else begin
            err_dst_rdy = 1'b1;
         end
      end
   end

   // Watches both handshakes and checks that a stalled word holds still
   initial begin
      popped       = 1'b0;
      stalled      = 1'b0;
      held_word    = '0;
      stall_errors = 0;
      forever begin
         @(posedge clk);
         popped = fifo_src_rdy && fifo_dst_rdy;
         if (err_src_rdy && err_dst_rdy) begin
            rx_q.push_back(err_data);
         end
         if (stalled && arst_n) begin
            assert (err_src_rdy && (err_data == held_word)) else begin
               stall_errors = stall_errors + 1;
               $display("%s: err_data_o changed or src_rdy dropped while stalled", current_test);
            end
         end
         stalled   = err_src_rdy && !err_dst_rdy;
         held_word = err_data;
      end
   end

   function automatic sample_entry_t make_entry(input logic sob, input logic has_time,
                                                input logic eob, input logic eop,
                                                input logic [63:0] t, input logic [31:0] s);
      sample_entry_t e;
      e            = '0;
      e.sob        = sob;
      e.has_time   = has_time;
      e.eob        = eob;
      e.eop        = eop;
      e.entry_time = t;
      e.sample     = s;
      return e;
   endfunction

   task automatic check_value(input string what, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      check_count = check_count + 1;
      assert (act_v === exp_v) else begin
         error_count = error_count + 1;
         $display("error %s %s expected %h actual %h", current_test, what, exp_v, act_v);
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      check_count = check_count + 1;
      assert (cond === 1'b1) else begin
         error_count = error_count + 1;
         $display("%s: %s", current_test, what);
      end
   endtask

   task automatic start_test(input string name);
      current_test    = name;
      errors_at_start = error_count + stall_errors;
      test_count      = test_count + 1;
   endtask

   task automatic finish_test();
      int n;
      n = error_count + stall_errors - errors_at_start;
      if (n == 0) begin
         $display("test %s ok", current_test);
      end else begin
         $display("test %s had %0d errors", current_test, n);
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      set_stb      = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(negedge clk);
      set_stb = 1'b0;
   endtask

   task automatic set_backpressure(input logic [1:0] mode);
      @(posedge clk);
      bp_mode = mode;
   endtask

   task automatic load_staged();
      @(posedge clk);
      while (stage_q.size() > 0) begin
         entry_q.push_back(stage_q.pop_front());
      end
   endtask

   task automatic wait_run();
      int n;
      n = 0;
      while (!run && n < WAIT_LIMIT) begin
         @(negedge clk);
         n = n + 1;
      end
      check_true(run, "run_o never rose for the burst");
   endtask

   task automatic wait_feeder_empty(input logic forbid_run);
      int n;
      n = 0;
      while (entry_rd < entry_q.size() && n < WAIT_LIMIT) begin
         @(posedge clk);
         if (forbid_run) begin
            check_true(!run, "run_o rose while entries were being discarded");
         end
         n = n + 1;
      end
      check_true(entry_rd == entry_q.size(), "DUT stopped taking entries");
   endtask

   task automatic expect_packet(input logic [3:0] count, input logic [31:0] msg,
                                input logic [63:0] stamp);
      stream_word_t exp_w;
      int           n;
      n = 0;
      while (rx_q.size() - rx_rd < CTX_WORDS && n < WAIT_LIMIT) begin
         @(negedge clk);
         n = n + 1;
      end
      check_true(rx_q.size() - rx_rd >= CTX_WORDS, "context packet did not arrive");
      if (rx_q.size() - rx_rd >= CTX_WORDS) begin
         for (int i = 0; i < CTX_WORDS; i++) begin
            exp_w     = '0;
            exp_w.sop = (i == 0);
            exp_w.eop = (i == CTX_WORDS - 1);
            case (i)
               0:       exp_w.data = {CTX_HEADER[31:4], count};
               1:       exp_w.data = stream_id;
               2:       exp_w.data = stamp[63:32];
               3:       exp_w.data = stamp[31:0];
               default: exp_w.data = msg;
            endcase
            check_value($sformatf("packet word %0d", i), 64'(exp_w), 64'(rx_q[rx_rd]));
            rx_rd = rx_rd + 1;
         end
      end
   endtask

   task automatic strobe_sample(input logic [31:0] exp_s);
      @(negedge clk);
      strobe = 1'b1;
      check_true(run, "run_o low while strobing inside a burst");
      @(negedge clk);
      strobe = 1'b0;
      check_value("sample_o", 64'(exp_s), 64'(sample));
   endtask

   // Holds time below the start, then at start plus 2, and strobes the first n_strobe entries
   task automatic timed_burst(input logic [63:0] start, input int n, input int n_strobe,
                              input logic eop_all);
      logic [31:0] smp [$];
      @(negedge clk);
      vita_time = start - 64'd20;
      for (int i = 0; i < n; i++) begin
         smp.push_back($urandom());
         stage_q.push_back(make_entry(i == 0, i == 0, i == n - 1, eop_all || (i == n - 1),
                                      start, smp[i]));
      end
      load_staged();
      repeat (4) @(negedge clk);
      check_true(!run, "run_o rose before the burst start time");
      check_value("entries left", 64'(n), 64'(entry_q.size() - entry_rd));
      vita_time = start + 64'd2;
      wait_run();
      for (int i = 0; i < n_strobe; i++) begin
         strobe_sample(smp[i]);
      end
      if (n_strobe == n) begin
         check_true(!run, "run_o still high after the eob entry");
      end
   endtask

   task automatic test_timed_burst();
      start_test("timed_burst");
      write_setting(SR_STREAMID, stream_id);
      timed_burst(64'd1000, 4, 4, 1'b0);
      expect_packet(err_pkts, CODE_ACK, 64'd1002);
      err_pkts = err_pkts + 4'd1;
      finish_test();
   endtask

   task automatic test_late_burst();
      start_test("late_burst");
      @(negedge clk);
      vita_time = 64'd5000;
      stage_q.push_back(make_entry(1'b1, 1'b1, 1'b0, 1'b0, 64'd4000, $urandom()));
      stage_q.push_back(make_entry(1'b0, 1'b0, 1'b0, 1'b0, 64'd4000, $urandom()));
      stage_q.push_back(make_entry(1'b0, 1'b0, 1'b1, 1'b1, 64'd4000, $urandom()));
      load_staged();
      wait_feeder_empty(1'b1);
      expect_packet(err_pkts, CODE_LATE, 64'd5000);
      err_pkts = err_pkts + 4'd1;
      finish_test();
   endtask

   task automatic test_underrun();
      logic [31:0] s0;
      logic [31:0] s1;
      int          pulses;
      start_test("underrun");
      s0 = $urandom();
      s1 = $urandom();
      @(negedge clk);
      vita_time = 64'd6000;
      stage_q.push_back(make_entry(1'b1, 1'b1, 1'b0, 1'b0, 64'd6000, s0));
      stage_q.push_back(make_entry(1'b0, 1'b0, 1'b0, 1'b0, 64'd6000, s1));
      load_staged();
      wait_run();
      strobe_sample(s0);
      strobe_sample(s1);
      // Nothing is left, so this strobe finds the FIFO empty
      @(negedge clk);
      strobe = 1'b1;
      @(negedge clk);
      strobe = 1'b0;
      pulses = 0;
      repeat (6) begin
         if (underrun) begin
            pulses = pulses + 1;
         end
         @(negedge clk);
      end
      check_value("underrun_o pulses", 64'd1, 64'(pulses));
      check_true(!run, "run_o still high after the underrun");
      stage_q.push_back(make_entry(1'b0, 1'b0, 1'b0, 1'b0, 64'd6000, $urandom()));
      stage_q.push_back(make_entry(1'b0, 1'b0, 1'b1, 1'b1, 64'd6000, $urandom()));
      load_staged();
      wait_feeder_empty(1'b1);
      expect_packet(err_pkts, CODE_UNDERRUN, 64'd6000);
      err_pkts = err_pkts + 4'd1;
      finish_test();
   endtask

   task automatic test_flow_control();
      start_test("flow_control");
      // Clear restarts the consumed count so the messages count from here
      write_setting(SR_CLEAR, 32'd0);
      write_setting(SR_FLOW_CADENCE, 32'd2);
      @(negedge clk);
      vita_time = 64'd7000;
      for (int k = 0; k < 4; k++) begin
         stage_q.push_back(make_entry(1'b0, 1'b0, 1'b1, 1'b1, 64'd0, $urandom()));
         load_staged();
         wait_feeder_empty(1'b1);
         repeat (8) @(negedge clk);
      end
      expect_packet(flow_pkts, 32'd2, 64'd7000);
      flow_pkts = flow_pkts + 4'd1;
      expect_packet(flow_pkts, 32'd4, 64'd7000);
      flow_pkts = flow_pkts + 4'd1;
      check_value("extra report words", 64'd0, 64'(rx_q.size() - rx_rd));
      finish_test();
   endtask

   task automatic test_priority();
      start_test("priority");
      set_backpressure(2'd1);
      // Two eop entries complete the cadence while the eob raises an ack
      timed_burst(64'd9000, 2, 2, 1'b1);
      repeat (6) @(negedge clk);
      check_true(err_src_rdy, "no report offered while the output was held");
      // The held word must be the header of the error packet
      check_value("held report word", 64'({4'b0001, CTX_HEADER[31:4], err_pkts}),
                  64'(err_data));
      set_backpressure(2'd2);
      expect_packet(err_pkts, CODE_ACK, 64'd9002);
      err_pkts = err_pkts + 4'd1;
      expect_packet(flow_pkts, 32'd6, 64'd9002);
      flow_pkts = flow_pkts + 4'd1;
      set_backpressure(2'd0);
      finish_test();
   endtask

   task automatic test_clear();
      start_test("clear");
      write_setting(SR_FLOW_CADENCE, 32'd0);
      timed_burst(64'd12000, 4, 2, 1'b0);
      write_setting(SR_CLEAR, 32'd0);
      repeat (2) @(negedge clk);
      check_true(!run, "run_o still high after clear");
      wait_feeder_empty(1'b1);
      repeat (20) @(negedge clk);
      check_value("report words after clear", 64'd0, 64'(rx_q.size() - rx_rd));
      timed_burst(64'd14000, 4, 4, 1'b0);
      expect_packet(err_pkts, CODE_ACK, 64'd14002);
      err_pkts = err_pkts + 4'd1;
      finish_test();
   endtask

   initial begin
      arst_n       = 1'b0;
      set_stb      = 1'b0;
      set_bus      = '0;
      vita_time    = '0;
      strobe       = 1'b0;
      bp_mode      = 2'd0;
      rx_rd        = 0;
      error_count  = 0;
      check_count  = 0;
      test_count   = 0;
      err_pkts     = 4'd0;
      flow_pkts    = 4'd0;
      current_test = "reset";
      void'($urandom(SEED));
      stream_id    = $urandom();
      repeat (RESET_CYCLES) @(negedge clk);
      check_true(!run && !underrun && !err_src_rdy && !fifo_dst_rdy,
                 "outputs not idle after reset");
      arst_n = 1'b1;
      test_timed_burst();
      test_late_burst();
      test_underrun();
      test_flow_control();
      test_priority();
      test_clear();
      $display("tests %0d, checks %0d, errors %0d", test_count, check_count,
               error_count + stall_errors);
      if (error_count + stall_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/vita_tx_chain.sv ====
// ##########################################################
// Transmit back end from stamped sample entries to the DSP strobe
// Error and ack reports take priority over flow reports on err_data_o
// Clear does not reach the output mux
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module vita_tx_chain import vita_tx_pkg::*; (
   input  wire           clk_i,
   input  wire           arst_n_i,
   input  wire           set_stb_i,
   input  setting_bus_t  set_i,
   input  wire  [63:0]   vita_time_i,
   input  sample_entry_t sample_fifo_i,
   input  wire           sample_fifo_src_rdy_i,
   output logic          sample_fifo_dst_rdy_o,
   input  wire           strobe_i,
   output logic [31:0]   sample_o,
   output logic          run_o,
   output logic          underrun_o,
   output stream_word_t  err_data_o,
   output logic          err_src_rdy_o,
   input  wire           err_dst_rdy_i
);

   logic         clear;
   logic [31:0]  streamid;
   logic [15:0]  flow_cadence;
   logic         error;
   logic         ack;
   logic [31:0]  error_code;
   logic         packet_consumed;
   logic         flow_trigger;
   logic [31:0]  consumed_count;
   stream_word_t err_data;
   logic         err_src_rdy;
   logic         err_dst_rdy;
   stream_word_t flow_data;
   logic         flow_src_rdy;
   logic         flow_dst_rdy;

   vita_tx_setting_regs u_setting_regs (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .set_stb_i(set_stb_i), .set_i(set_i),
      .clear_o(clear), .streamid_o(streamid), .flow_cadence_o(flow_cadence)
   );

   vita_tx_control u_control (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .clear_i(clear),
      .vita_time_i(vita_time_i),
      .sample_fifo_i(sample_fifo_i),
      .sample_fifo_src_rdy_i(sample_fifo_src_rdy_i),
      .sample_fifo_dst_rdy_o(sample_fifo_dst_rdy_o),
      .strobe_i(strobe_i), .sample_o(sample_o),
      .run_o(run_o), .underrun_o(underrun_o),
      .error_o(error), .ack_o(ack), .error_code_o(error_code),
      .packet_consumed_o(packet_consumed)
   );

   trigger_context_pkt u_trigger (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .clear_i(clear),
      .cadence_i(flow_cadence), .packet_consumed_i(packet_consumed),
      .trigger_o(flow_trigger), .consumed_count_o(consumed_count)
   );

   gen_context_pkt gen_err (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .clear_i(clear),
      .trigger_i(error | ack), .streamid_i(streamid),
      .vita_time_i(vita_time_i), .message_i(error_code),
      .data_o(err_data), .src_rdy_o(err_src_rdy), .dst_rdy_i(err_dst_rdy)
   );

   gen_context_pkt gen_flow (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .clear_i(clear),
      .trigger_i(flow_trigger), .streamid_i(streamid),
      .vita_time_i(vita_time_i), .message_i(consumed_count),
      .data_o(flow_data), .src_rdy_o(flow_src_rdy), .dst_rdy_i(flow_dst_rdy)
   );

   context_pkt_mux u_mux (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .data0_i(err_data), .src0_rdy_i(err_src_rdy), .dst0_rdy_o(err_dst_rdy),
      .data1_i(flow_data), .src1_rdy_i(flow_src_rdy), .dst1_rdy_o(flow_dst_rdy),
      .data_o(err_data_o), .src_rdy_o(err_src_rdy_o), .dst_rdy_i(err_dst_rdy_i)
   );

endmodule

`default_nettype wire

// ==== hdl/context_pkt_mux.sv ====
// ##########################################################
// Two-input packet mux, input 0 wins at a packet boundary
// Output is combinational from the inputs, no buffering
// The grant locks at the first transfer and frees at eop
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module context_pkt_mux import vita_tx_pkg::*; (
   input  wire          clk_i,
   input  wire          arst_n_i,
   input  stream_word_t data0_i,
   input  wire          src0_rdy_i,
   output logic         dst0_rdy_o,
   input  stream_word_t data1_i,
   input  wire          src1_rdy_i,
   output logic         dst1_rdy_o,
   output stream_word_t data_o,
   output logic         src_rdy_o,
   input  wire          dst_rdy_i
);

   logic locked_q;
   logic grant_q;
   logic sel;
   logic xfer;

   // Between packets pick input 0 whenever it has something
   assign sel = locked_q ? grant_q : !src0_rdy_i;

   assign data_o     = sel ? data1_i : data0_i;
   assign src_rdy_o  = sel ? src1_rdy_i : src0_rdy_i;
   assign dst0_rdy_o = !sel && dst_rdy_i;
   assign dst1_rdy_o = sel && dst_rdy_i;
   assign xfer       = src_rdy_o && dst_rdy_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         locked_q <= 1'b0;
         grant_q  <= 1'b0;
      end else if (xfer) begin
         if (data_o.eop) begin
            locked_q <= 1'b0;
         end else begin
            locked_q <= 1'b1;
            grant_q  <= sel;
         end
      end
   end

   // Inside a packet the next word offered is never the start of another packet
   a_grant_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (xfer && !data_o.eop) |=> (!src_rdy_o || !data_o.sop));

endmodule

`default_nettype wire

// ==== hdl/gen_context_pkt.sv ====
// ##########################################################
// One five-word context packet per trigger, triggers while busy are lost
// Time and message are captured at the trigger, stream id is live
// Clear drops a packet only before its first word has gone out
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module gen_context_pkt import vita_tx_pkg::*; (
   input  wire          clk_i,
   input  wire          arst_n_i,
   input  wire          clear_i,
   input  wire          trigger_i,
   input  wire  [31:0]  streamid_i,
   input  wire  [63:0]  vita_time_i,
   input  wire  [31:0]  message_i,
   output stream_word_t data_o,
   output logic         src_rdy_o,
   input  wire          dst_rdy_i
);

   logic                 busy_q;
   logic [CTX_IDX_W-1:0] idx_q;
   logic [3:0]           count_q;
   logic [63:0]          time_q;
   logic [31:0]          msg_q;
   logic                 take;
   logic                 last_word;

   assign src_rdy_o = busy_q;
   assign take      = busy_q && dst_rdy_i;
   assign last_word = (idx_q == CTX_IDX_W'(CTX_WORDS - 1));

   always_comb begin
      data_o     = '0;
      data_o.sop = (idx_q == '0);
      data_o.eop = last_word;
      case (idx_q)
         CTX_IDX_W'(0): data_o.data = CTX_HEADER | {28'd0, count_q};
         CTX_IDX_W'(1): data_o.data = streamid_i;
         CTX_IDX_W'(2): data_o.data = time_q[63:32];
         CTX_IDX_W'(3): data_o.data = time_q[31:0];
         default:       data_o.data = msg_q;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q  <= 1'b0;
         idx_q   <= '0;
         count_q <= '0;
      end else if (clear_i && (idx_q == '0) && !take) begin
         // A started packet runs to eop, the mux downstream is never cleared
         busy_q <= 1'b0;
      end else if (!busy_q) begin
         idx_q <= '0;
         if (trigger_i) begin
            busy_q <= 1'b1;
         end
      end else if (take) begin
         if (last_word) begin
            busy_q  <= 1'b0;
            idx_q   <= '0;
            count_q <= count_q + 4'd1;
         end else begin
            idx_q <= idx_q + CTX_IDX_W'(1);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (trigger_i && !busy_q) begin
         time_q <= vita_time_i;
         msg_q  <= message_i;
      end
   end

   a_hold_while_stalled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (src_rdy_o && !dst_rdy_i) |=> $stable(data_o));

endmodule

`default_nettype wire

// ==== hdl/trigger_context_pkt.sv ====
// ##########################################################
// Flow report trigger, one pulse every cadence packets
// Cadence 0 stops triggering but the consumed count still runs
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module trigger_context_pkt (
   input  wire         clk_i,
   input  wire         arst_n_i,
   input  wire         clear_i,
   input  wire  [15:0] cadence_i,
   input  wire         packet_consumed_i,
   output logic        trigger_o,
   output logic [31:0] consumed_count_o
);

   logic [15:0] phase_q;
   logic        wrap;

   // Wrap also when the cadence was lowered below the current phase
   assign wrap = ({1'b0, phase_q} + 17'd1) >= {1'b0, cadence_i};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         phase_q          <= '0;
         trigger_o        <= 1'b0;
         consumed_count_o <= '0;
      end else if (clear_i) begin
         phase_q          <= '0;
         trigger_o        <= 1'b0;
         consumed_count_o <= '0;
      end else begin
         trigger_o <= 1'b0;
         if (packet_consumed_i) begin
            consumed_count_o <= consumed_count_o + 32'd1;
            if (cadence_i != 16'd0) begin
               if (wrap) begin
                  phase_q   <= '0;
                  trigger_o <= 1'b1;
               end else begin
                  phase_q <= phase_q + 16'd1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/vita_tx_control.sv ====
// ##########################################################
// Timed burst release toward the DSP strobe
// A head entry without sob in idle is discarded through its eob
// Late means system time strictly past the entry time
// Status outputs are one-cycle pulses, one cycle after the event
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module vita_tx_control import vita_tx_pkg::*; (
   input  wire           clk_i,
   input  wire           arst_n_i,
   input  wire           clear_i,
   input  wire  [63:0]   vita_time_i,
   input  sample_entry_t sample_fifo_i,
   input  wire           sample_fifo_src_rdy_i,
   output logic          sample_fifo_dst_rdy_o,
   input  wire           strobe_i,
   output logic [31:0]   sample_o,
   output logic          run_o,
   output logic          underrun_o,
   output logic          error_o,
   output logic          ack_o,
   output logic [31:0]   error_code_o,
   output logic          packet_consumed_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_TIME,
      ST_RUN,
      ST_FLUSH
   } state_t;

   state_t state_q;
   logic   pop;
   logic   timed_head;
   logic   head_late;
   logic   head_due;
   logic   late_start;
   logic   underrun_now;
   logic   burst_done;

   assign timed_head = sample_fifo_i.sob && sample_fifo_i.has_time;
   assign head_late  = vita_time_i > sample_fifo_i.entry_time;
   assign head_due   = vita_time_i >= sample_fifo_i.entry_time;

   // Entries leave only on a strobe while running, or freely while flushing
   assign sample_fifo_dst_rdy_o = (state_q == ST_FLUSH) || ((state_q == ST_RUN) && strobe_i);
   assign pop   = sample_fifo_dst_rdy_o && sample_fifo_src_rdy_i;
   assign run_o = (state_q == ST_RUN);

   assign late_start   = (state_q == ST_IDLE) && sample_fifo_src_rdy_i && timed_head && head_late;
   assign underrun_now = (state_q == ST_RUN) && strobe_i && !sample_fifo_src_rdy_i;
   assign burst_done   = (state_q == ST_RUN) && pop && sample_fifo_i.eob;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q           <= ST_IDLE;
         error_o           <= 1'b0;
         ack_o             <= 1'b0;
         underrun_o        <= 1'b0;
         packet_consumed_o <= 1'b0;
      end else if (clear_i) begin
         state_q           <= ST_IDLE;
         error_o           <= 1'b0;
         ack_o             <= 1'b0;
         underrun_o        <= 1'b0;
         packet_consumed_o <= 1'b0;
      end else begin
         error_o           <= late_start || underrun_now;
         ack_o             <= burst_done;
         underrun_o        <= underrun_now;
         packet_consumed_o <= pop && sample_fifo_i.eop;
         case (state_q)
            ST_IDLE: begin
               if (sample_fifo_src_rdy_i) begin
                  if (!sample_fifo_i.sob || late_start) begin
                     state_q <= ST_FLUSH;
                  end else if (!sample_fifo_i.has_time || head_due) begin
                     state_q <= ST_RUN;
                  end else begin
                     state_q <= ST_WAIT_TIME;
                  end
               end
            end
            ST_WAIT_TIME: begin
               if (head_due) begin
                  state_q <= ST_RUN;
               end
            end
            ST_RUN: begin
               if (underrun_now) begin
                  state_q <= ST_FLUSH;
               end else if (burst_done) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               // Flush ends with the eob entry itself
               if (pop && sample_fifo_i.eob) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == ST_RUN) && pop) begin
         sample_o <= sample_fifo_i.sample;
      end
      if (late_start) begin
         error_code_o <= CODE_LATE;
      end else if (underrun_now) begin
         error_code_o <= CODE_UNDERRUN;
      end else if (burst_done) begin
         error_code_o <= CODE_ACK;
      end
   end

   // A burst only starts on a head entry that is still offered
   a_run_needs_entry: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(run_o) |-> $past(sample_fifo_src_rdy_i));

   a_ack_error_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(error_o && ack_o));

endmodule

`default_nettype wire

// ==== hdl/vita_tx_setting_regs.sv ====
// ##########################################################
// Settings decoder for the transmit chain
// Stream id and cadence read 0 after reset, so flow reports are off
// A clear write gives one pulse in the cycle after the write
// ##########################################################

`timescale 1ns/1ns
`default_nettype none

module vita_tx_setting_regs import vita_tx_pkg::*; (
   input  wire          clk_i,
   input  wire          arst_n_i,
   input  wire          set_stb_i,
   input  setting_bus_t set_i,
   output logic         clear_o,
   output logic [31:0]  streamid_o,
   output logic [15:0]  flow_cadence_o
);

   logic wr_clear;
   logic wr_streamid;
   logic wr_cadence;

   assign wr_clear    = set_stb_i && (set_i.addr == SR_CLEAR);
   assign wr_streamid = set_stb_i && (set_i.addr == SR_STREAMID);
   assign wr_cadence  = set_stb_i && (set_i.addr == SR_FLOW_CADENCE);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         clear_o        <= 1'b0;
         streamid_o     <= '0;
         flow_cadence_o <= '0;
      end else begin
         // The data word of a clear write is ignored
         clear_o <= wr_clear;
         if (wr_streamid) begin
            streamid_o <= set_i.data;
         end
         if (wr_cadence) begin
            flow_cadence_o <= set_i.data[15:0];
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/vita_tx_pkg.sv ====
// ##########################################################
// Shared types and constants of the timed transmit back end
// A context packet always has CTX_WORDS words and occ is 0
// Setting addresses are absolute, there is no base offset
// ##########################################################

`default_nettype none

package vita_tx_pkg;

   // Layout follows the 36-bit FIFO convention, occ on top and data at the bottom
   typedef struct packed {
      logic [1:0]  occ;
      logic        eop;
      logic        sop;
      logic [31:0] data;
   } stream_word_t;

   // One sample as stamped by the deframer
   typedef struct packed {
      logic        has_time;
      logic        sob;
      logic        eob;
      logic        eop;
      logic [63:0] entry_time;
      logic [31:0] sample;
   } sample_entry_t;

   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] data;
   } setting_bus_t;

   localparam logic [7:0] SR_CLEAR        = 8'd1;
   localparam logic [7:0] SR_STREAMID     = 8'd2;
   localparam logic [7:0] SR_FLOW_CADENCE = 8'd3;

   localparam logic [31:0] CODE_ACK      = 32'd1;
   localparam logic [31:0] CODE_UNDERRUN = 32'd2;
   localparam logic [31:0] CODE_LATE     = 32'd8;

   // Context packet type with a stream id, the low nibble carries the packet count
   localparam logic [31:0] CTX_HEADER = 32'h4000_0050;
   localparam int          CTX_WORDS  = 5;
   localparam int          CTX_IDX_W  = $clog2(CTX_WORDS);

endpackage

`default_nettype wire
